// ==== rtl/corePkg.sv ====
package corePkg;

	localparam int nRegs = 16;
	localparam int regIdxBits = 4;
	localparam int dataBits = 32;
	localparam int immBits = 12;	// long form immediate, before extension

	typedef enum logic [3:0]
	{
		opNop = 4'd0,
		opAdd = 4'd1,
		opSub = 4'd2,
		opAnd = 4'd3,
		opOr = 4'd4,
		opXor = 4'd5,
		opMovi = 4'd6,
		opCmpEq = 4'd7,
		opCmpGt = 4'd8,
		opInv = 4'd9
	} aluOpT;

	typedef struct packed
	{
		logic valid;
		logic isPred;
		logic predFalse;	// run only while T is clear
		aluOpT op;
		logic [regIdxBits-1:0] rn;
		logic [regIdxBits-1:0] rm;
		logic [regIdxBits-1:0] ro;
		logic useImm;
		logic [dataBits-1:0] imm;
	} decOpT;

	typedef struct packed
	{
		logic valid;
		logic executed;
		logic writeEn;
		logic [regIdxBits-1:0] rn;
		logic [dataBits-1:0] data;
		logic setT;
		logic tVal;
		logic invalid;
	} exResT;

	typedef struct packed
	{
		logic valid;
		logic executed;
		logic wrote;
		logic [regIdxBits-1:0] rn;
		logic [dataBits-1:0] data;
		logic invalid;
	} retireT;

	// same opcode map for both forms, 9..15 are invalid
	function automatic aluOpT opFromNibble(input logic [3:0] nib);
		aluOpT op;
		if (nib > 4'd8)
			op = opInv;
		else
			op = aluOpT'(nib);
		return op;
	endfunction

endpackage

// ==== rtl/coreTop.sv ====
module coreTop
(
	input logic clock,
	input logic arstN,
	input logic istrValid,
	input logic [31:0] istrWord,
	output corePkg::retireT ret,
	output logic tFlag
);

	import corePkg::*;

	decOpT idOp;
	exResT exRes;
	logic [regIdxBits-1:0] rdIdxM;
	logic [regIdxBits-1:0] rdIdxO;
	logic [dataBits-1:0] rdDataM;
	logic [dataBits-1:0] rdDataO;

	decOp uDec
	(
		.clock(clock),
		.arstN(arstN),
		.istrValid(istrValid),
		.istrWord(istrWord),
		.idOp(idOp)
	);

	exUnit uEx
	(
		.idOp(idOp),
		.rdDataM(rdDataM),
		.rdDataO(rdDataO),
		.tFlag(tFlag),	// T feeds back for predication
		.rdIdxM(rdIdxM),
		.rdIdxO(rdIdxO),
		.exRes(exRes)
	);

	wbRegFile uWb
	(
		.clock(clock),
		.arstN(arstN),
		.rdIdxM(rdIdxM),
		.rdIdxO(rdIdxO),
		.exRes(exRes),
		.rdDataM(rdDataM),
		.rdDataO(rdDataO),
		.tFlag(tFlag),
		.ret(ret)
	);

endmodule

// ==== rtl/decLongOp.sv ====
module decLongOp
(
	input logic [31:0] istr,
	output corePkg::decOpT dec
);

	import corePkg::*;

	logic [immBits-1:0] imm12;
	logic [dataBits-1:0] simm;

	// top nibble from the high half, low byte from the prefix half
	assign imm12 = {istr[19:16], istr[7:0]};

	assign simm = {{(dataBits-immBits){imm12[immBits-1]}}, imm12};

	always_comb
	begin
		dec = '0;
		dec.op = opFromNibble(istr[31:28]);
		dec.rn = istr[27:24];
		dec.rm = istr[23:20];

		// no third register in this form
		dec.ro = '0;

		/* the immediate always stands in for operand B,
		   MOVI just passes it through */
		dec.useImm = 1'b1;
		dec.imm = simm;

		dec.valid = 1'b0;
		dec.isPred = 1'b0;
		dec.predFalse = 1'b0;
	end

endmodule

// ==== rtl/decOp.sv ====
module decOp
(
	input logic clock,
	input logic arstN,
	input logic istrValid,
	input logic [31:0] istrWord,
	output corePkg::decOpT idOp
);

	import corePkg::*;

	decOpT shortOp;
	decOpT longOp;
	decOpT nextOp;
	logic isLong;
	logic isPred;
	logic predFalse;

	decShortOp uShort
	(
		.istr(istrWord[15:0]),
		.dec(shortOp)
	);

	decLongOp uLong
	(
		.istr(istrWord),
		.dec(longOp)
	);

	always_comb
	begin
		isLong = 1'b0;
		isPred = 1'b0;
		predFalse = 1'b0;

		casez (istrWord[15:10])
			6'b11100?:	// E0..E7, predicated
			begin
				isLong = 1'b1;
				isPred = 1'b1;
				predFalse = istrWord[10];
			end
			6'b11110?:	// F0..F7
			begin
				isLong = 1'b1;
			end
			default:
			begin
				isLong = 1'b0;	// plain 16-bit, high half ignored
			end
		endcase

		nextOp = isLong ? longOp : shortOp;
		nextOp.isPred = isPred;
		nextOp.predFalse = predFalse;
		nextOp.valid = istrValid;
	end

	// payload only moves when a word arrives
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			idOp <= '0;
		else if (istrValid)
			idOp <= nextOp;
		else
			idOp.valid <= 1'b0;
	end

endmodule

// ==== rtl/decShortOp.sv ====
module decShortOp
(
	input logic [15:0] istr,
	output corePkg::decOpT dec
);

	import corePkg::*;

	aluOpT op;
	logic [dataBits-1:0] zimm;

	assign op = opFromNibble(istr[15:12]);

	// {Rm,Ro} taken as one byte for MOVI
	assign zimm = {{(dataBits-8){1'b0}}, istr[7:0]};

	always_comb
	begin
		dec = '0;
		dec.op = op;
		dec.rn = istr[11:8];
		dec.rm = istr[7:4];
		dec.ro = istr[3:0];
		dec.imm = zimm;

		// predication and valid are filled in by decOp
		dec.valid = 1'b0;
		dec.isPred = 1'b0;
		dec.predFalse = 1'b0;

		if (op == opMovi)
		begin
			dec.useImm = 1'b1;	// Rn = imm8, zero extended
		end
		else
		begin
			dec.useImm = 1'b0;	// operand B comes from Ro
		end
	end

endmodule

// ==== rtl/exUnit.sv ====
module exUnit
(
	input corePkg::decOpT idOp,
	input logic [corePkg::dataBits-1:0] rdDataM,
	input logic [corePkg::dataBits-1:0] rdDataO,
	input logic tFlag,
	output logic [corePkg::regIdxBits-1:0] rdIdxM,
	output logic [corePkg::regIdxBits-1:0] rdIdxO,
	output corePkg::exResT exRes
);

	import corePkg::*;

	logic [dataBits-1:0] opB;
	logic [dataBits-1:0] result;
	logic predOk;
	logic cmpVal;
	logic isWriteOp;
	logic isCmpOp;

	assign rdIdxM = idOp.rm;
	assign rdIdxO = idOp.ro;

	assign opB = idOp.useImm ? idOp.imm : rdDataO;

	// true-sense wants T set, false-sense wants it clear
	assign predOk = !idOp.isPred || (tFlag != idOp.predFalse);

	always_comb
	begin
		result = '0;
		cmpVal = 1'b0;
		case (idOp.op)
			opAdd: result = rdDataM + opB;
			opSub: result = rdDataM - opB;
			opAnd: result = rdDataM & opB;
			opOr: result = rdDataM | opB;
			opXor: result = rdDataM ^ opB;
			opMovi: result = opB;	// already extended by the decoder
			opCmpEq:
			begin
				cmpVal = (rdDataM == opB);
				result = {{(dataBits-1){1'b0}}, cmpVal};
			end
			opCmpGt:
			begin
				cmpVal = ($signed(rdDataM) > $signed(opB));
				result = {{(dataBits-1){1'b0}}, cmpVal};
			end
			default: result = '0;	// nop and invalid
		endcase
	end

	assign isWriteOp = (idOp.op inside {opAdd, opSub, opAnd, opOr, opXor, opMovi});
	assign isCmpOp = (idOp.op == opCmpEq) || (idOp.op == opCmpGt);

	always_comb
	begin
		exRes.valid = idOp.valid;
		exRes.executed = idOp.valid && predOk;
		exRes.writeEn = exRes.executed && isWriteOp;
		exRes.rn = idOp.rn;
		exRes.data = result;
		exRes.setT = exRes.executed && isCmpOp;
		exRes.tVal = cmpVal;
		exRes.invalid = idOp.valid && (idOp.op == opInv);
	end

endmodule

// ==== rtl/wbRegFile.sv ====
module wbRegFile
(
	input logic clock,
	input logic arstN,
	input logic [corePkg::regIdxBits-1:0] rdIdxM,
	input logic [corePkg::regIdxBits-1:0] rdIdxO,
	input corePkg::exResT exRes,
	output logic [corePkg::dataBits-1:0] rdDataM,
	output logic [corePkg::dataBits-1:0] rdDataO,
	output logic tFlag,
	output corePkg::retireT ret
);

	import corePkg::*;

	logic [dataBits-1:0] regs [nRegs];
	logic tReg;

	// read straight from the array, so a write at this edge is seen next op
	assign rdDataM = regs[rdIdxM];
	assign rdDataO = regs[rdIdxO];
	assign tFlag = tReg;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < nRegs; i++)
				regs[i] <= '0;
			tReg <= 1'b0;
			ret <= '0;
		end
		else
		begin
			if (exRes.writeEn)
				regs[exRes.rn] <= exRes.data;
			if (exRes.setT)
				tReg <= exRes.tVal;
			ret.valid <= exRes.valid;
			ret.executed <= exRes.executed;
			ret.wrote <= exRes.writeEn;
			ret.rn <= exRes.rn;
			ret.data <= exRes.data;
			ret.invalid <= exRes.invalid;
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the core testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module coreTb -f vlog.f -o coreSim \
	&& ./obj_dir/coreSim > sim.log 2>&1 \
	&& cat sim.log \
	&& grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
	&& echo "run.sh: simulation passed" \
	|| { cat sim.log 2>/dev/null; echo "run.sh: simulation failed"; exit 1; }

// ==== verif/coreChecker.sv ====
module coreChecker
(
	input logic clock,
	input logic arstN,
	input corePkg::retireT ret,
	input logic tFlag,
	input logic expPush,
	input corePkg::retireT expRet,
	input logic expT,
	output int nPass,
	output int nFail,
	output int nPending
);

	import corePkg::*;

	typedef struct packed
	{
		retireT ret;
		logic t;	// T flag right after this retire
		logic [31:0] due;	// falling edge the retire belongs on
	} expectT;

	expectT expQ[$];
	expectT incoming;
	int passCnt = 0;
	int failCnt = 0;
	int pendCnt = 0;
	int testIdx = 0;
	int testErrs = 0;
	int edgeCnt = 0;

	assign nPass = passCnt;
	assign nFail = failCnt;
	assign nPending = pendCnt;

	task automatic compareField(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		if (expVal !== actVal)
		begin
			$display("[FAIL] %0t %s expected %0h got %0h", $time, name, expVal, actVal);
			testErrs++;
		end
	endtask

	task automatic checkRetire();
		expectT want;
		if (expQ.size() == 0)
		begin
			$display("retire at %0t arrived with no expected entry left", $time);
			failCnt++;
		end
		else
		begin
			want = expQ.pop_front();
			testErrs = 0;
			compareField("ret.valid edge", want.due, 32'(edgeCnt));
			compareField("ret.executed", 32'(want.ret.executed), 32'(ret.executed));
			compareField("ret.wrote", 32'(want.ret.wrote), 32'(ret.wrote));
			compareField("ret.invalid", 32'(want.ret.invalid), 32'(ret.invalid));
			if (want.ret.wrote)	// rn and data only mean something on a write
			begin
				compareField("ret.rn", 32'(want.ret.rn), 32'(ret.rn));
				compareField("ret.data", want.ret.data, ret.data);
			end
			compareField("tFlag", 32'(want.t), 32'(tFlag));
			if (testErrs == 0)
			begin
				$display("[PASS] test %0d at %0t", testIdx, $time);
				passCnt++;
			end
			else
			begin
				$display("test %0d at %0t had %0d wrong fields", testIdx, $time, testErrs);
				failCnt++;
			end
			testIdx++;
		end
	endtask

	// sample on the falling edge, outputs settle after the rising one
	always @(negedge clock)
	begin
		edgeCnt++;
		if (!arstN)
		begin
			if (ret.valid !== 1'b0 || tFlag !== 1'b0)
			begin
				$display("retire or T flag active during reset at %0t", $time);
				failCnt++;
			end
		end
		else
		begin
			if (ret.valid === 1'b1)
				checkRetire();
			if (expPush)
			begin
				incoming.ret = expRet;
				incoming.t = expT;
				incoming.due = 32'(edgeCnt + 2);	// decode edge, then retire edge
				expQ.push_back(incoming);
			end
		end
		pendCnt = expQ.size();
	end

endmodule

// ==== verif/coreTb.sv ====
module coreTb;

	import corePkg::*;

	localparam int nSteps = 29;
	localparam int resetCycles = 8;
	localparam int cycleLimit = resetCycles + nSteps + 20;

	localparam logic [7:0] pfxU = 8'hF0;	// unconditional long form
	localparam logic [7:0] pfxT = 8'hE0;	// runs while T is set
	localparam logic [7:0] pfxF = 8'hE4;	// runs while T is clear

	typedef struct packed
	{
		logic [31:0] word;
		retireT ret;
		logic t;
	} stepT;

	logic clock;
	logic arstN;
	logic istrValid;
	logic [31:0] istrWord;
	retireT ret;
	logic tFlag;
	logic expPush;
	retireT expRet;
	logic expT;
	int nPass;
	int nFail;
	int nPending;
	int cycles;
	int nFilled;
	logic timedOut;
	stepT steps [nSteps];

	coreTop dut
	(
		.clock(clock),
		.arstN(arstN),
		.istrValid(istrValid),
		.istrWord(istrWord),
		.ret(ret),
		.tFlag(tFlag)
	);

	coreChecker watcher
	(
		.clock(clock),
		.arstN(arstN),
		.ret(ret),
		.tFlag(tFlag),
		.expPush(expPush),
		.expRet(expRet),
		.expT(expT),
		.nPass(nPass),
		.nFail(nFail),
		.nPending(nPending)
	);

	always #5 clock = ~clock;

	function automatic logic [31:0] shortWord(input logic [3:0] opc, input logic [3:0] rn,
		input logic [3:0] rm, input logic [3:0] ro);
		return {16'h0000, opc, rn, rm, ro};
	endfunction

	// imm top nibble sits in the high half, low byte next to the prefix
	function automatic logic [31:0] longWord(input logic [7:0] pfx, input logic [3:0] opc,
		input logic [3:0] rn, input logic [3:0] rm, input logic [11:0] imm);
		return {opc, rn, rm, imm[11:8], pfx, imm[7:0]};
	endfunction

	function automatic retireT wroteRet(input logic [3:0] rn, input logic [31:0] data);
		retireT r;
		r = '0;
		r.valid = 1'b1;
		r.executed = 1'b1;
		r.wrote = 1'b1;
		r.rn = rn;
		r.data = data;
		return r;
	endfunction

	function automatic retireT plainRet(input logic executed, input logic invalid);
		retireT r;
		r = '0;
		r.valid = 1'b1;
		r.executed = executed;
		r.invalid = invalid;
		return r;
	endfunction

	task automatic addStep(input logic [31:0] word, input retireT r, input logic t);
		steps[nFilled].word = word;
		steps[nFilled].ret = r;
		steps[nFilled].t = t;
		nFilled++;
	endtask

	task automatic fillSteps();
		nFilled = 0;
		addStep(shortWord(4'h1, 4'd1, 4'd14, 4'd15), wroteRet(4'd1, 32'h0), 1'b0);	// unwritten
		addStep(longWord(pfxU, 4'h6, 4'd2, 4'd0, 12'h123), wroteRet(4'd2, 32'h123), 1'b0);
		addStep(longWord(pfxU, 4'h6, 4'd3, 4'd0, 12'h800), wroteRet(4'd3, 32'hFFFFF800), 1'b0);
		addStep(longWord(pfxU, 4'h6, 4'd4, 4'd0, 12'hFFF), wroteRet(4'd4, 32'hFFFFFFFF), 1'b0);
		addStep(longWord(pfxU, 4'h6, 4'd5, 4'd0, 12'h7FF), wroteRet(4'd5, 32'h7FF), 1'b0);
		// each ALU op reads the register written just before it
		addStep(shortWord(4'h1, 4'd6, 4'd5, 4'd2), wroteRet(4'd6, 32'h922), 1'b0);
		addStep(shortWord(4'h2, 4'd7, 4'd6, 4'd3), wroteRet(4'd7, 32'h1122), 1'b0);
		addStep(shortWord(4'h3, 4'd8, 4'd7, 4'd4), wroteRet(4'd8, 32'h1122), 1'b0);
		addStep(shortWord(4'h4, 4'd9, 4'd8, 4'd2), wroteRet(4'd9, 32'h1123), 1'b0);
		addStep(shortWord(4'h5, 4'd10, 4'd9, 4'd3), wroteRet(4'd10, 32'hFFFFE923), 1'b0);
		addStep(shortWord(4'h6, 4'd11, 4'hA, 4'h5), wroteRet(4'd11, 32'hA5), 1'b0);
		addStep(longWord(pfxU, 4'h1, 4'd12, 4'd11, 12'hFFB), wroteRet(4'd12, 32'hA0), 1'b0);
		// compares
		addStep(shortWord(4'h7, 4'd0, 4'd8, 4'd7), plainRet(1'b1, 1'b0), 1'b1);
		addStep(shortWord(4'h8, 4'd0, 4'd3, 4'd2), plainRet(1'b1, 1'b0), 1'b0);	// negative Rm
		addStep(shortWord(4'h8, 4'd0, 4'd2, 4'd3), plainRet(1'b1, 1'b0), 1'b1);
		// predication, T is set here
		addStep(longWord(pfxT, 4'h6, 4'd13, 4'd0, 12'h055), wroteRet(4'd13, 32'h55), 1'b1);
		addStep(longWord(pfxF, 4'h6, 4'd13, 4'd0, 12'h077), plainRet(1'b0, 1'b0), 1'b1);
		addStep(shortWord(4'h1, 4'd14, 4'd13, 4'd0), wroteRet(4'd14, 32'h55), 1'b1);
		addStep(longWord(pfxF, 4'h7, 4'd0, 4'd0, 12'h001), plainRet(1'b0, 1'b0), 1'b1);
		addStep(longWord(pfxU, 4'h7, 4'd0, 4'd0, 12'h001), plainRet(1'b1, 1'b0), 1'b0);
		addStep(longWord(pfxF, 4'h1, 4'd15, 4'd2, 12'h001), wroteRet(4'd15, 32'h124), 1'b0);
		addStep(longWord(pfxT, 4'h2, 4'd15, 4'd15, 12'h001), plainRet(1'b0, 1'b0), 1'b0);
		addStep(shortWord(4'h5, 4'd1, 4'd15, 4'd0), wroteRet(4'd1, 32'h124), 1'b0);
		// invalid opcodes in both forms, then a NOP
		addStep(shortWord(4'h9, 4'd1, 4'd2, 4'd3), plainRet(1'b1, 1'b1), 1'b0);
		addStep(shortWord(4'hB, 4'd4, 4'd5, 4'd6), plainRet(1'b1, 1'b1), 1'b0);
		addStep(longWord(pfxU, 4'hF, 4'd1, 4'd2, 12'h000), plainRet(1'b1, 1'b1), 1'b0);
		addStep(longWord(pfxU, 4'hA, 4'd1, 4'd2, 12'h000), plainRet(1'b1, 1'b1), 1'b0);
		addStep(shortWord(4'h0, 4'd0, 4'd0, 4'd0), plainRet(1'b1, 1'b0), 1'b0);
		// short ADD with junk in the high half
		addStep(shortWord(4'h1, 4'd2, 4'd1, 4'd0) | 32'hF0F00000, wroteRet(4'd2, 32'h124), 1'b0);
	endtask

	task automatic endRun();
		$display("summary: %0d of %0d tests passed, %0d failures, %0d expected retires missing",
			nPass, nSteps, nFail, nPending);
		if (nFail == 0 && nPending == 0 && nPass == nSteps && !timedOut)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	endtask

	initial
	begin
		clock = 1'b0;
		arstN = 1'b0;
		istrValid = 1'b0;
		istrWord = '0;
		expPush = 1'b0;
		expRet = '0;
		expT = 1'b0;
		timedOut = 1'b0;
		fillSteps();
		repeat (resetCycles) @(posedge clock);
		arstN <= 1'b1;
		@(posedge clock);
		for (int i = 0; i < nSteps; i++)
		begin
			istrValid <= 1'b1;
			istrWord <= steps[i].word;
			expPush <= 1'b1;
			expRet <= steps[i].ret;
			expT <= steps[i].t;
			@(posedge clock);
		end
		istrValid <= 1'b0;
		istrWord <= '0;
		expPush <= 1'b0;
		while (nPending != 0)
			@(posedge clock);
		repeat (3) @(posedge clock);	// catch stray retires
		endRun();
	end

	initial
	begin
		cycles = 0;
		while (cycles < cycleLimit)
		begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: run stopped after %0d cycles with retires still pending", cycles);
		timedOut = 1'b1;
		endRun();
	end

endmodule

// ==== vlog.f ====
rtl/corePkg.sv
rtl/decShortOp.sv
rtl/decLongOp.sv
rtl/decOp.sv
rtl/exUnit.sv
rtl/wbRegFile.sv
rtl/coreTop.sv
verif/coreChecker.sv
verif/coreTb.sv
